// File: alert_cfg.svh
/*
 * Alert handler configuration: alert and class counts, field widths
 * and the APB register map.
 */
`ifndef ALERT_CFG_SVH
`define ALERT_CFG_SVH

`define ALERT_NUM_ALERTS   4
`define ALERT_NUM_CLASSES  4
`define ALERT_APB_AW       8
`define ALERT_ACCUM_W      8
`define ALERT_ESC_W        16

// register offsets
`define ADDR_INTR_STATE    8'h00
`define ADDR_INTR_ENABLE   8'h04
`define ADDR_ALERT_EN      8'h08
`define ADDR_ALERT_CLASS   8'h0C
`define ADDR_INTEG_STATUS  8'h10
`define ADDR_CLASS_CLR     8'h14
`define ADDR_ESC_STATE     8'h18
// per class banks, stride 4
`define ADDR_THRESH_BASE   8'h20
`define ADDR_ESC_CYC_BASE  8'h30
`define ADDR_ACCUM_BASE    8'h40

`endif

// File: alert_pkg.sv
/*
 * Alert handler types: vectors per alert and per class, counters,
 * APB fields and the escalation state encoding.
 */
`include "alert_cfg.svh"

package alert_pkg;

  // one bit per alert line / per class
  typedef logic [`ALERT_NUM_ALERTS-1:0]  alert_vec_t;
  typedef logic [`ALERT_NUM_CLASSES-1:0] class_vec_t;

  typedef logic [1:0] class_idx_t;

  // alert k uses bits 2k+1:2k
  typedef logic [2*`ALERT_NUM_ALERTS-1:0] alert_class_map_t;

  typedef logic [`ALERT_ACCUM_W-1:0] accum_t;
  typedef logic [`ALERT_ESC_W-1:0]   esc_cnt_t;

  // apb fields
  typedef logic [`ALERT_APB_AW-1:0] apb_addr_t;
  typedef logic [31:0]              apb_data_t;

  typedef enum logic [1:0] {
    ESC_IDLE     = 2'd0,
    ESC_ACTIVE   = 2'd1,
    ESC_TERMINAL = 2'd2
  } esc_state_e;

endpackage

// File: alert_reg_if.sv
/*
 * Link between the register block and the escalator: configuration
 * one way, per class events and status the other.
 */
`include "alert_cfg.svh"

interface alert_reg_if import alert_pkg::*; ();

  // configuration from the register block
  alert_vec_t       alert_en;
  alert_class_map_t alert_class;
  accum_t           thresh     [`ALERT_NUM_CLASSES];
  esc_cnt_t         esc_cycles [`ALERT_NUM_CLASSES];
  class_vec_t       clr;

  // status from the escalator
  class_vec_t       class_evt;
  accum_t           accum      [`ALERT_NUM_CLASSES];
  esc_state_e       esc_state  [`ALERT_NUM_CLASSES];

  modport regs_mp (
    output alert_en, alert_class, thresh, esc_cycles, clr,
    input  class_evt, accum, esc_state
  );

  modport esc_mp (
    input  alert_en, alert_class, thresh, esc_cycles, clr,
    output class_evt, accum, esc_state
  );

endinterface

// File: alert_receiver.sv
/*
 * Differential alert receiver. Decodes the alert pair, answers with the
 * ack pair and flags one integrity event per run of invalid samples.
 */
module alert_receiver (
  input  logic clk_i,
  input  logic reset_i,
  input  logic alert_p_i,
  input  logic alert_n_i,
  output logic ack_p_o,
  output logic ack_n_o,
  output logic alert_evt_o,
  output logic integ_evt_o
);

  logic alert_p_q;
  logic alert_n_q;
  logic ack_q;
  logic evt_q;
  logic integ_q;
  logic [1:0] fail_cnt_q;

  logic asserted;
  logic idle;
  logic invalid;

  // decode of the sampled pair
  assign asserted = alert_p_q & ~alert_n_q;
  assign idle     = ~alert_p_q & alert_n_q;
  assign invalid  = (alert_p_q == alert_n_q);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      alert_p_q <= 1'b0;
      alert_n_q <= 1'b1;
    end else begin
      alert_p_q <= alert_p_i;
      alert_n_q <= alert_n_i;
    end
  end

  // ack follows the held alert, drops only on a clean idle
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ack_q <= 1'b0;
      evt_q <= 1'b0;
    end else begin
      evt_q <= asserted & ~ack_q;
      if (asserted) begin
        ack_q <= 1'b1;
      end else if (idle) begin
        ack_q <= 1'b0;
      end
    end
  end

  // saturates at 2 so a long episode fires once
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      fail_cnt_q <= 2'd0;
      integ_q    <= 1'b0;
    end else begin
      integ_q <= invalid && (fail_cnt_q == 2'd1);
      if (!invalid) begin
        fail_cnt_q <= 2'd0;
      end else if (fail_cnt_q != 2'd2) begin
        fail_cnt_q <= fail_cnt_q + 2'd1;
      end
    end
  end

  assign ack_p_o     = ack_q;
  assign ack_n_o     = ~ack_q;
  assign alert_evt_o = evt_q;
  assign integ_evt_o = integ_q;

endmodule

// File: alert_apb_regs.sv
/*
 * APB register file of the alert handler: configuration, interrupt and
 * integrity status, and read access to the escalator status.
 */
`include "alert_cfg.svh"

module alert_apb_regs import alert_pkg::*; (
  input  logic       clk_i,
  input  logic       reset_i,
  input  logic       psel_i,
  input  logic       penable_i,
  input  logic       pwrite_i,
  input  apb_addr_t  paddr_i,
  input  apb_data_t  pwdata_i,
  output apb_data_t  prdata_o,
  output logic       pready_o,
  output logic       pslverr_o,
  input  alert_vec_t integ_evt_i,
  output class_vec_t intr_o,
  alert_reg_if.regs_mp cfg
);

  class_vec_t       intr_state_q;
  class_vec_t       intr_enable_q;
  alert_vec_t       alert_en_q;
  alert_class_map_t alert_class_q;
  alert_vec_t       integ_status_q;
  class_vec_t       clr_q;
  accum_t           thresh_q  [`ALERT_NUM_CLASSES];
  esc_cnt_t         esc_cyc_q [`ALERT_NUM_CLASSES];

  logic       wr_en;
  logic       addr_hit;
  apb_data_t  rdata;
  class_vec_t intr_clr;
  alert_vec_t integ_clr;

  assign wr_en = psel_i & penable_i & pwrite_i;

  // write-one-to-clear masks
  assign intr_clr  = (wr_en && paddr_i == `ADDR_INTR_STATE) ?
                     pwdata_i[`ALERT_NUM_CLASSES-1:0] : '0;
  assign integ_clr = (wr_en && paddr_i == `ADDR_INTEG_STATUS) ?
                     pwdata_i[`ALERT_NUM_ALERTS-1:0] : '0;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      intr_state_q   <= '0;
      intr_enable_q  <= '0;
      alert_en_q     <= '0;
      alert_class_q  <= '0;
      integ_status_q <= '0;
      clr_q          <= '0;
      for (int c = 0; c < `ALERT_NUM_CLASSES; c++) begin
        thresh_q[c]  <= '0;
        esc_cyc_q[c] <= '0;
      end
    end else begin
      clr_q <= '0;
      if (wr_en) begin
        case (paddr_i)
          `ADDR_INTR_ENABLE: intr_enable_q <= pwdata_i[`ALERT_NUM_CLASSES-1:0];
          `ADDR_ALERT_EN:    alert_en_q    <= pwdata_i[`ALERT_NUM_ALERTS-1:0];
          `ADDR_ALERT_CLASS: alert_class_q <= pwdata_i[2*`ALERT_NUM_ALERTS-1:0];
          `ADDR_CLASS_CLR:   clr_q         <= pwdata_i[`ALERT_NUM_CLASSES-1:0];
          default: begin
            for (int c = 0; c < `ALERT_NUM_CLASSES; c++) begin
              if (paddr_i == apb_addr_t'(`ADDR_THRESH_BASE + 4 * c)) begin
                thresh_q[c] <= pwdata_i[`ALERT_ACCUM_W-1:0];
              end
              if (paddr_i == apb_addr_t'(`ADDR_ESC_CYC_BASE + 4 * c)) begin
                esc_cyc_q[c] <= pwdata_i[`ALERT_ESC_W-1:0];
              end
            end
          end
        endcase
      end
      // a new event beats a clear in the same cycle
      intr_state_q   <= (intr_state_q & ~intr_clr) | cfg.class_evt;
      integ_status_q <= (integ_status_q & ~integ_clr) | integ_evt_i;
    end
  end

  // read mux
  always_comb begin
    rdata    = '0;
    addr_hit = 1'b1;
    case (paddr_i)
      `ADDR_INTR_STATE:   rdata = apb_data_t'(intr_state_q);
      `ADDR_INTR_ENABLE:  rdata = apb_data_t'(intr_enable_q);
      `ADDR_ALERT_EN:     rdata = apb_data_t'(alert_en_q);
      `ADDR_ALERT_CLASS:  rdata = apb_data_t'(alert_class_q);
      `ADDR_INTEG_STATUS: rdata = apb_data_t'(integ_status_q);
      `ADDR_CLASS_CLR:    rdata = '0;
      `ADDR_ESC_STATE: begin
        for (int c = 0; c < `ALERT_NUM_CLASSES; c++) begin
          rdata[2*c +: 2] = cfg.esc_state[c];
        end
      end
      default: begin
        addr_hit = 1'b0;
        for (int c = 0; c < `ALERT_NUM_CLASSES; c++) begin
          if (paddr_i == apb_addr_t'(`ADDR_THRESH_BASE + 4 * c)) begin
            rdata    = apb_data_t'(thresh_q[c]);
            addr_hit = 1'b1;
          end
          if (paddr_i == apb_addr_t'(`ADDR_ESC_CYC_BASE + 4 * c)) begin
            rdata    = apb_data_t'(esc_cyc_q[c]);
            addr_hit = 1'b1;
          end
          if (paddr_i == apb_addr_t'(`ADDR_ACCUM_BASE + 4 * c)) begin
            rdata    = apb_data_t'(cfg.accum[c]);
            addr_hit = 1'b1;
          end
        end
      end
    endcase
  end

  assign prdata_o  = rdata;
  assign pready_o  = 1'b1;
  assign pslverr_o = psel_i & penable_i & ~addr_hit;

  assign intr_o = intr_state_q & intr_enable_q;

  // configuration out to the escalator
  assign cfg.alert_en    = alert_en_q;
  assign cfg.alert_class = alert_class_q;
  assign cfg.thresh      = thresh_q;
  assign cfg.esc_cycles  = esc_cyc_q;
  assign cfg.clr         = clr_q;

endmodule

// File: alert_escalator.sv
/*
 * Per class classification, saturating accumulation and escalation FSM.
 * Escalation holds until the class is cleared.
 */
`include "alert_cfg.svh"

module alert_escalator import alert_pkg::*; (
  input  logic       clk_i,
  input  logic       reset_i,
  input  alert_vec_t alert_evt_i,
  output class_vec_t esc_en_o,
  alert_reg_if.esc_mp cfg
);

  localparam int HIT_W = $clog2(`ALERT_NUM_ALERTS + 1);
  localparam int AW    = `ALERT_ACCUM_W;

  alert_vec_t       gated_evt;
  logic [HIT_W-1:0] hits       [`ALERT_NUM_CLASSES];
  accum_t           accum_next [`ALERT_NUM_CLASSES];
  class_vec_t       cyc_done;

  class_vec_t       class_evt_q;
  accum_t           accum_q [`ALERT_NUM_CLASSES];
  esc_state_e       state_q [`ALERT_NUM_CLASSES];
  esc_cnt_t         cyc_q   [`ALERT_NUM_CLASSES];

  assign gated_evt = alert_evt_i & cfg.alert_en;

  // route enabled alerts to their class and count them
  always_comb begin : class_route
    logic [AW:0] sum;
    for (int c = 0; c < `ALERT_NUM_CLASSES; c++) begin
      hits[c] = '0;
      for (int k = 0; k < `ALERT_NUM_ALERTS; k++) begin
        if (gated_evt[k] && cfg.alert_class[2*k +: 2] == class_idx_t'(c)) begin
          hits[c] = hits[c] + 1'b1;
        end
      end
      sum = {1'b0, accum_q[c]} + hits[c];
      // saturate at all ones
      accum_next[c] = sum[AW] ? '1 : sum[AW-1:0];
      cyc_done[c]   = ({1'b0, cyc_q[c]} + 1'b1) >= {1'b0, cfg.esc_cycles[c]};
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      class_evt_q <= '0;
      for (int c = 0; c < `ALERT_NUM_CLASSES; c++) begin
        accum_q[c] <= '0;
        state_q[c] <= ESC_IDLE;
        cyc_q[c]   <= '0;
      end
    end else begin
      for (int c = 0; c < `ALERT_NUM_CLASSES; c++) begin
        class_evt_q[c] <= (hits[c] != '0);
        if (cfg.clr[c]) begin
          accum_q[c] <= '0;
          state_q[c] <= ESC_IDLE;
          cyc_q[c]   <= '0;
        end else begin
          accum_q[c] <= accum_next[c];
          case (state_q[c])
            ESC_IDLE: begin
              // zero threshold keeps the class idle
              if (cfg.thresh[c] != '0 && accum_q[c] >= cfg.thresh[c]) begin
                state_q[c] <= ESC_ACTIVE;
                cyc_q[c]   <= '0;
              end
            end
            ESC_ACTIVE: begin
              if (cyc_done[c]) begin
                state_q[c] <= ESC_TERMINAL;
              end else begin
                cyc_q[c] <= cyc_q[c] + 1'b1;
              end
            end
            ESC_TERMINAL: begin
              state_q[c] <= ESC_TERMINAL;
            end
            default: begin
              state_q[c] <= ESC_IDLE;
            end
          endcase
        end
      end
    end
  end

  always_comb begin
    for (int c = 0; c < `ALERT_NUM_CLASSES; c++) begin
      esc_en_o[c] = (state_q[c] != ESC_IDLE);
    end
  end

  // status back to the register block
  assign cfg.class_evt = class_evt_q;
  assign cfg.accum     = accum_q;
  assign cfg.esc_state = state_q;

endmodule

// File: alert_handler.sv
/*
 * Alert handler top: differential alert receivers, APB registers and
 * the per class escalator.
 */
`include "alert_cfg.svh"

module alert_handler import alert_pkg::*; (
  input  logic       clk_i,
  input  logic       reset_i,
  // apb
  input  logic       psel_i,
  input  logic       penable_i,
  input  logic       pwrite_i,
  input  apb_addr_t  paddr_i,
  input  apb_data_t  pwdata_i,
  output apb_data_t  prdata_o,
  output logic       pready_o,
  output logic       pslverr_o,
  // alert pairs
  input  alert_vec_t alert_p_i,
  input  alert_vec_t alert_n_i,
  output alert_vec_t ack_p_o,
  output alert_vec_t ack_n_o,
  // per class
  output class_vec_t intr_o,
  output class_vec_t esc_en_o
);

  alert_vec_t raw_evt;
  alert_vec_t integ_evt;
  alert_vec_t alert_evt;

  alert_reg_if u_reg_if ();

  for (genvar k = 0; k < `ALERT_NUM_ALERTS; k++) begin : gen_rx
    alert_receiver u_alert_receiver (
      .clk_i       ( clk_i        ),
      .reset_i     ( reset_i      ),
      .alert_p_i   ( alert_p_i[k] ),
      .alert_n_i   ( alert_n_i[k] ),
      .ack_p_o     ( ack_p_o[k]   ),
      .ack_n_o     ( ack_n_o[k]   ),
      .alert_evt_o ( raw_evt[k]   ),
      .integ_evt_o ( integ_evt[k] )
    );
  end

  // an integrity failure also counts as an alert of that line
  assign alert_evt = raw_evt | integ_evt;

  alert_apb_regs u_alert_apb_regs (
    .clk_i       ( clk_i           ),
    .reset_i     ( reset_i         ),
    .psel_i      ( psel_i          ),
    .penable_i   ( penable_i       ),
    .pwrite_i    ( pwrite_i        ),
    .paddr_i     ( paddr_i         ),
    .pwdata_i    ( pwdata_i        ),
    .prdata_o    ( prdata_o        ),
    .pready_o    ( pready_o        ),
    .pslverr_o   ( pslverr_o       ),
    .integ_evt_i ( integ_evt       ),
    .intr_o      ( intr_o          ),
    .cfg         ( u_reg_if.regs_mp )
  );

  alert_escalator u_alert_escalator (
    .clk_i       ( clk_i           ),
    .reset_i     ( reset_i         ),
    .alert_evt_i ( alert_evt       ),
    .esc_en_o    ( esc_en_o        ),
    .cfg         ( u_reg_if.esc_mp )
  );

endmodule

// File: tb_alert_handler.sv
/*
 * Alert handler testbench. Runs the command lines of the input file
 * over APB and the alert pairs and checks the responses.
 */
`include "alert_cfg.svh"

module tb_alert_handler;
  timeunit 1ns;
  timeprecision 1ps;

  logic                          clk_i;
  logic                          reset_i;
  logic                          psel_i;
  logic                          penable_i;
  logic                          pwrite_i;
  logic [7:0]                    paddr_i;
  logic [31:0]                   pwdata_i;
  logic [31:0]                   prdata_o;
  logic                          pready_o;
  logic                          pslverr_o;
  logic [`ALERT_NUM_ALERTS-1:0]  alert_p_i;
  logic [`ALERT_NUM_ALERTS-1:0]  alert_n_i;
  logic [`ALERT_NUM_ALERTS-1:0]  ack_p_o;
  logic [`ALERT_NUM_ALERTS-1:0]  ack_n_o;
  logic [`ALERT_NUM_CLASSES-1:0] intr_o;
  logic [`ALERT_NUM_CLASSES-1:0] esc_en_o;

  string       lines[$];
  string       line;
  int          fd;
  int          wd_cycles = 0;
  logic [7:0]  cmd;
  logic [31:0] arg_a;
  logic [31:0] arg_b;

  alert_handler u_alert_handler (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Done: errors found");
    $fatal(1, "run aborted");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected) begin
      abort_run($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, got, expected));
    end
  endtask

  // register map of the handler, word aligned
  function automatic logic addr_is_mapped(input logic [7:0] addr);
    if (addr[1:0] != 2'b00) begin
      return 1'b0;
    end
    return (addr <= 8'h18) || (addr >= 8'h20 && addr <= 8'h4c);
  endfunction

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
    @(posedge clk_i);
    psel_i    <= 1'b1;
    penable_i <= 1'b0;
    pwrite_i  <= 1'b1;
    paddr_i   <= addr;
    pwdata_i  <= data;
    @(posedge clk_i);
    penable_i <= 1'b1;
    @(posedge clk_i);
    psel_i    <= 1'b0;
    penable_i <= 1'b0;
    // one idle cycle so a clear pulse has reached the escalator
    @(posedge clk_i);
  endtask

  task automatic apb_read(input logic [7:0] addr, input logic [31:0] expected);
    @(posedge clk_i);
    psel_i    <= 1'b1;
    penable_i <= 1'b0;
    pwrite_i  <= 1'b0;
    paddr_i   <= addr;
    @(posedge clk_i);
    penable_i <= 1'b1;
    @(negedge clk_i);
    check_value("pready_o", pready_o, 1'b1);
    check_value("prdata_o", prdata_o, expected);
    check_value("pslverr_o", pslverr_o, !addr_is_mapped(addr));
    @(posedge clk_i);
    psel_i    <= 1'b0;
    penable_i <= 1'b0;
  endtask

  task automatic wait_for_ack(input int idx, input logic level);
    int waited;
    waited = 0;
    @(negedge clk_i);
    while (ack_p_o[idx] !== level) begin
      waited++;
      if (waited > 20) begin
        abort_run($sformatf("ack of alert %0d did not reach %0d within 20 cycles",
                            idx, level));
      end
      @(negedge clk_i);
    end
    check_value("ack_n_o", ack_n_o[idx], !level);
  endtask

  task automatic alert_handshake(input int idx);
    @(posedge clk_i);
    alert_p_i[idx] <= 1'b1;
    alert_n_i[idx] <= 1'b0;
    wait_for_ack(idx, 1'b1);
    @(posedge clk_i);
    alert_p_i[idx] <= 1'b0;
    alert_n_i[idx] <= 1'b1;
    wait_for_ack(idx, 1'b0);
  endtask

  task automatic integrity_fault(input int idx);
    @(posedge clk_i);
    alert_p_i[idx] <= 1'b1;
    alert_n_i[idx] <= 1'b1;
    repeat (3) @(posedge clk_i);
    alert_p_i[idx] <= 1'b0;
    alert_n_i[idx] <= 1'b1;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    // a broken pair never counts as a handshake
    check_value("ack_p_o", ack_p_o[idx], 1'b0);
    check_value("ack_n_o", ack_n_o[idx], 1'b1);
  endtask

  initial begin : watchdog
    wait (wd_cycles > 0);
    repeat (wd_cycles) @(posedge clk_i);
    abort_run($sformatf("timeout: the test did not finish within %0d cycles", wd_cycles));
  end

  initial begin
    reset_i   = 1'b1;
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
    paddr_i   = '0;
    pwdata_i  = '0;
    alert_p_i = '0;
    alert_n_i = '1;
    fd = $fopen("alert_handler_input.txt", "r");
    if (fd == 0) begin
      abort_run("could not open alert_handler_input.txt");
    end
    while ($fgets(line, fd) != 0) begin
      lines.push_back(line);
    end
    $fclose(fd);
    wd_cycles = lines.size() * 50;
    repeat (4) @(posedge clk_i);
    reset_i <= 1'b0;
    @(negedge clk_i);
    check_value("ack_p_o", ack_p_o, '0);
    check_value("ack_n_o", ack_n_o, 32'hf);
    check_value("esc_en_o", esc_en_o, '0);
    foreach (lines[i]) begin
      if (lines[i].len() < 2 || lines[i].getc(0) == "#") begin
        continue;
      end
      void'($sscanf(lines[i], "%c %h %h", cmd, arg_a, arg_b));
      case (cmd)
        "W": apb_write(arg_a[7:0], arg_b);
        "R": apb_read(arg_a[7:0], arg_b);
        "A": alert_handshake(arg_a);
        "F": integrity_fault(arg_a);
        "D": repeat (arg_a) @(posedge clk_i);
        "E": begin
          @(negedge clk_i);
          check_value("esc_en_o", esc_en_o, arg_a);
        end
        "N": begin
          @(negedge clk_i);
          check_value("intr_o", intr_o, arg_a);
        end
        default: abort_run($sformatf("unknown command in line %0d of the input file", i + 1));
      endcase
    end
    repeat (4) @(posedge clk_i);
    $display("Done: no errors");
    $finish;
  end

endmodule

// File: alert_handler_input.txt
# cmd and hex fields: W addr data, R addr expect, A alert, F alert
# E esc_en mask, N intr mask, D cycles
W 04 f
W 08 7
W 0c d4
W 24 2
W 34 5
R 0c d4
R 24 2
R 34 5
R 50 0
A 0
N 1
R 40 1
W 00 1
N 0
A 3
N 0
A 1
E 0
A 2
E 2
N 2
D 10
R 18 8
E 2
W 14 2
E 0
R 44 0
F 0
R 10 1
R 40 2
N 3
E 0

// File: files.f
+incdir+.
alert_pkg.sv
alert_reg_if.sv
alert_receiver.sv
alert_apb_regs.sv
alert_escalator.sv
alert_handler.sv
tb_alert_handler.sv
